// ==== build.f ====
+incdir+design
design/vic_loader_pkg.sv
design/load_addr_map.sv
design/prg_loader.sv
design/basic_ptr_inject.sv
design/tape_fetch.sv
design/mem_port_mux.sv
design/vic_loader_top.sv
test/vic_loader_chk.sv
test/tb_vic_loader.sv

// ==== design/basic_ptr_inject.sv ====
/*
  BASIC pointer update after a PRG download, plus the cartridge auto reset.
  Steps 1..31 run one per cycle from the falling edge of the PRG download.
  The beats are internal writes and leave through the configuration bus.
*/
`include "vic_loader_config.svh"

module basic_ptr_inject (
    input  logic                     clk_sys,
    input  logic                     reset,
    input  vic_loader_pkg::dl_kind_t kind_i,
    input  logic [15:0]              prg_addr_i,
    input  logic                     cart_hit_i,
    output vic_loader_pkg::load_wr_t inject_o,
    output logic                     force_reset_o
);
    import vic_loader_pkg::*;

    localparam logic [15:0] PTR_ADDR [8] = '{
        `VL_PTR_ADDR_0, `VL_PTR_ADDR_1, `VL_PTR_ADDR_2, `VL_PTR_ADDR_3,
        `VL_PTR_ADDR_4, `VL_PTR_ADDR_5, `VL_PTR_ADDR_6, `VL_PTR_ADDR_7
    };

    logic [4:0]  state;
    logic        prg_dl_d;
    logic        auto_reset;
    logic        ptr_slot;
    logic        inj_wr;
    logic [15:0] inj_addr;
    logic [7:0]  inj_data;

    // Odd steps 1..15 carry a pointer byte
    assign ptr_slot = state[0] && !state[4];

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            state         <= 5'd0;
            prg_dl_d      <= 1'b0;
            auto_reset    <= 1'b0;
            inj_wr        <= 1'b0;
            force_reset_o <= 1'b0;
        end else begin
            prg_dl_d      <= (kind_i == DL_PRG);
            inj_wr        <= ptr_slot;
            force_reset_o <= 1'b0;
            if (cart_hit_i) begin
                auto_reset <= 1'b1;
            end
            if (prg_dl_d && kind_i != DL_PRG) begin
                state <= 5'd1;
            end else if (state == `VL_INJECT_LAST) begin
                state         <= 5'd0;
                force_reset_o <= auto_reset;
                auto_reset    <= 1'b0;
            end else if (state != 5'd0) begin
                state <= state + 5'd1;
            end
        end
    end

    // Even table slots take the low byte of the end address
    always_ff @(posedge clk_sys) begin
        if (ptr_slot) begin
            inj_addr <= PTR_ADDR[state[3:1]];
            inj_data <= state[1] ? prg_addr_i[15:8] : prg_addr_i[7:0];
        end
    end

    assign inject_o = '{addr: inj_addr, data: inj_data, wr: inj_wr};

endmodule

// ==== design/load_addr_map.sv ====
/*
  Image kind decode and target address map. Purely combinational.
  ROM offsets with bits 15..13 of 110 or 111 have no window and map to 0.
  An active injector beat takes over the PRG address path.
*/
module load_addr_map (
    input  vic_loader_pkg::host_dl_t host_i,
    input  logic [15:0]              prg_addr_i,
    input  logic [22:0]              tap_addr_i,
    input  vic_loader_pkg::load_wr_t inject_i,
    output vic_loader_pkg::dl_kind_t kind_o,
    output logic [22:0]              target_o,
    output logic                     internal_o
);
    import vic_loader_pkg::*;

    // Low RAM, colour/VIC area and the I/O block live inside the core
    function automatic logic prg_internal(input logic [15:0] a);
        return (a[15:10] == 6'b000000) || (a[15:12] == 4'h1) || (a[15:10] == 6'b100101);
    endfunction

    always_comb begin
        kind_o = DL_NONE;
        if (host_i.download) begin
            case (host_i.index)
                8'h00:        kind_o = DL_ROM;
                8'h01, 8'h41: kind_o = DL_PRG;
                8'h81:        kind_o = DL_TAP;
                default:      kind_o = DL_NONE;
            endcase
        end
    end

    always_comb begin
        target_o   = 23'h0;
        internal_o = 1'b0;
        if (inject_i.wr) begin
            target_o   = {7'h0, inject_i.addr};
            internal_o = prg_internal(inject_i.addr);
        end else begin
            case (kind_o)
                DL_ROM: begin
                    case (host_i.addr[15:13])
                        3'b000, 3'b001: target_o = {7'h0, host_i.addr[15:0]};
                        3'b010, 3'b011: target_o = {7'h0, 3'b111, host_i.addr[12:0]};
                        3'b100:         target_o = {7'h0, 3'b110, host_i.addr[12:0]};
                        3'b101:         target_o = {7'h0, 4'b1000, host_i.addr[11:0]};
                        default:        target_o = 23'h0;
                    endcase
                    internal_o = |target_o[15:14];
                end
                DL_PRG: begin
                    target_o   = {7'h0, prg_addr_i};
                    internal_o = prg_internal(prg_addr_i);
                end
                DL_TAP:  target_o = tap_addr_i;
                default: target_o = 23'h0;
            endcase
        end
    end

endmodule

// ==== design/mem_port_mux.sv ====
/*
  External memory port arbitration. Purely combinational.
  Priority: loader during a download, CPU while p2_h is high, tape fetch.
  ROM bytes outside the internal windows also go to memory.
*/
module mem_port_mux (
    input  vic_loader_pkg::dl_kind_t kind_i,
    input  logic                     p2_h_i,
    input  vic_loader_pkg::cpu_req_t cpu_i,
    input  vic_loader_pkg::load_wr_t load_i,
    input  logic [22:0]              target_i,
    input  logic                     internal_i,
    input  vic_loader_pkg::host_dl_t host_i,
    input  logic [22:0]              tap_addr_i,
    input  logic                     tap_oe_i,
    output vic_loader_pkg::mem_req_t mem_o,
    output vic_loader_pkg::load_wr_t conf_o
);
    import vic_loader_pkg::*;

    logic ext_wr;

    // Only decoded images may touch memory
    assign ext_wr = load_i.wr && !internal_i && (kind_i != DL_NONE);

    always_comb begin
        if (host_i.download) begin
            mem_o.addr = target_i;
            mem_o.din  = load_i.data;
            mem_o.we   = ext_wr;
            mem_o.oe   = 1'b0;
        end else if (p2_h_i) begin
            mem_o.addr = {7'h0, cpu_i.addr};
            mem_o.din  = cpu_i.data;
            mem_o.we   = cpu_i.sel && !cpu_i.r_wn;
            mem_o.oe   = cpu_i.sel && cpu_i.r_wn;
        end else begin
            mem_o.addr = tap_addr_i;
            mem_o.din  = cpu_i.data;
            mem_o.we   = 1'b0;
            mem_o.oe   = tap_oe_i;
        end
    end

    // Configuration bus sees internal beats only
    assign conf_o.addr = target_i[15:0];
    assign conf_o.data = load_i.data;
    assign conf_o.wr   = load_i.wr && internal_i;

endmodule

// ==== design/prg_loader.sv ====
/*
  Address tracking for PRG and TAP images, write strobe for all kinds.
  The strobe lands one cycle after host wr, so the host holds addr, dout
  and download until its next byte. TAP offset 0 is not stored; byte k
  sits at VL_TAP_BASE + k.
*/
`include "vic_loader_config.svh"

module prg_loader (
    input  logic                     clk_sys,
    input  logic                     reset,
    input  vic_loader_pkg::host_dl_t host_i,
    input  vic_loader_pkg::dl_kind_t kind_i,
    input  logic                     no_load_addr_i,
    output logic [15:0]              prg_addr_o,
    output logic [22:0]              tap_addr_o,
    output logic                     ram_wr_o,
    output logic                     cart_hit_o
);
    import vic_loader_pkg::*;

    // Strobe belongs to a PRG byte
    logic prg_beat;

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            ram_wr_o   <= 1'b0;
            prg_beat   <= 1'b0;
            cart_hit_o <= 1'b0;
        end else begin
            ram_wr_o   <= 1'b0;
            prg_beat   <= 1'b0;
            cart_hit_o <= prg_beat && (prg_addr_o == `VL_PRG_CART_ADDR);
            if (host_i.wr) begin
                case (kind_i)
                    DL_ROM: ram_wr_o <= 1'b1;
                    DL_PRG: begin
                        if (no_load_addr_i) begin
                            ram_wr_o <= 1'b1;
                            prg_beat <= 1'b1;
                        end else if (host_i.addr > 24'h1) begin
                            ram_wr_o <= 1'b1;
                            prg_beat <= 1'b1;
                        end
                    end
                    DL_TAP:  ram_wr_o <= (host_i.addr != 24'h0);
                    default: ram_wr_o <= 1'b0;
                endcase
            end
        end
    end

    // ============================================================
    // Address pointers
    // ============================================================
    always_ff @(posedge clk_sys) begin
        if (host_i.wr && kind_i == DL_PRG) begin
            if (no_load_addr_i) begin
                prg_addr_o <= (host_i.addr == 24'h0) ? `VL_PRG_CART_ADDR : prg_addr_o + 16'd1;
            end else if (host_i.addr == 24'h0) begin
                prg_addr_o[7:0] <= host_i.dout;
            end else if (host_i.addr == 24'h1) begin
                prg_addr_o[15:8] <= host_i.dout;
            end else if (host_i.addr != 24'h2) begin
                // Offset 2 lands on the header address itself
                prg_addr_o <= prg_addr_o + 16'd1;
            end
        end
        if (host_i.wr && kind_i == DL_TAP) begin
            tap_addr_o <= (host_i.addr == 24'h0) ? `VL_TAP_BASE : tap_addr_o + 23'd1;
        end
    end

endmodule

// ==== design/tape_fetch.sv ====
/*
  Reads the stored TAP image back into the tape FIFO, one byte per CPU phase.
  A read starts on a falling edge of p2_h and is handed over on the next
  rising edge. p2_h must stay low at least two cycles so the data,
  which returns one cycle after the address, is captured.
*/
`include "vic_loader_config.svh"

module tape_fetch (
    input  logic                     clk_sys,
    input  logic                     reset,
    input  vic_loader_pkg::host_dl_t host_i,
    input  vic_loader_pkg::dl_kind_t kind_i,
    input  logic [22:0]              tap_addr_i,
    input  logic                     p2_h_i,
    input  logic [7:0]               mem_dout_i,
    input  logic                     tap_full_i,
    output logic [22:0]              play_addr_o,
    output logic                     oe_o,
    output logic [7:0]               tap_data_o,
    output logic                     tap_wrreq_o,
    output logic                     tap_version_o
);
    import vic_loader_pkg::*;

    logic [22:0] last_addr;
    logic        p2_h_d;
    logic        tap_dl_d;

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            play_addr_o   <= `VL_TAP_BASE;
            last_addr     <= `VL_TAP_BASE;
            oe_o          <= 1'b0;
            tap_wrreq_o   <= 1'b0;
            tap_version_o <= 1'b0;
            p2_h_d        <= 1'b0;
            tap_dl_d      <= 1'b0;
        end else begin
            p2_h_d      <= p2_h_i;
            tap_dl_d    <= (kind_i == DL_TAP);
            tap_wrreq_o <= 1'b0;

            // One cycle past the download the last pointer is final
            if (kind_i == DL_TAP || tap_dl_d) begin
                last_addr <= tap_addr_i + 23'd1;
            end
            if (kind_i == DL_TAP) begin
                play_addr_o <= `VL_TAP_BASE + 23'd1;
                if (host_i.wr && {1'b0, host_i.addr} == `VL_TAP_VERSION_OFS) begin
                    tap_version_o <= host_i.dout[0];
                end
            end

            if (p2_h_d && !p2_h_i && !host_i.download &&
                play_addr_o != last_addr && !tap_full_i) begin
                oe_o <= 1'b1;
            end
            if (p2_h_i && !p2_h_d && oe_o) begin
                tap_wrreq_o <= 1'b1;
                oe_o        <= 1'b0;
                play_addr_o <= play_addr_o + 23'd1;
            end
        end
    end

    // Last sample before p2_h rises is the one handed over
    always_ff @(posedge clk_sys) begin
        if (!p2_h_i && oe_o) begin
            tap_data_o <= mem_dout_i;
        end
    end

endmodule

// ==== design/vic_loader_config.svh ====
/*
  Address constants for the VIC-20 media loader.
  TAP images are kept in external memory from VL_TAP_BASE upward.
  The pointer table follows the BASIC zero page layout of the stock ROMs.
*/
`ifndef VIC_LOADER_CONFIG_SVH
`define VIC_LOADER_CONFIG_SVH

// ============================================================
// Memory layout
// ============================================================
`define VL_TAP_BASE        23'h020000
`define VL_PRG_CART_ADDR   16'hA000

// BASIC start of variables, arrays, end of arrays, end of program
`define VL_PTR_ADDR_0      16'h002D
`define VL_PTR_ADDR_1      16'h002E
`define VL_PTR_ADDR_2      16'h002F
`define VL_PTR_ADDR_3      16'h0030
`define VL_PTR_ADDR_4      16'h0031
`define VL_PTR_ADDR_5      16'h0032
`define VL_PTR_ADDR_6      16'h00AE
`define VL_PTR_ADDR_7      16'h00AF

// Byte offset of the version field in a TAP header
`define VL_TAP_VERSION_OFS 25'h000000C
// Last step of the pointer write sequence
`define VL_INJECT_LAST     5'd31

`endif

// ==== design/vic_loader_pkg.sv ====
/*
  Shared types for the media loader and the memory port.
  Struct layouts are packed and match the bus widths of the core.
*/
package vic_loader_pkg;

    // Image kind decoded from the host index
    typedef enum logic [1:0] {
        DL_NONE,
        DL_ROM,
        DL_PRG,
        DL_TAP
    } dl_kind_t;

    // One beat of the host download stream
    typedef struct packed {
        logic        download;
        logic [7:0]  index;
        logic        wr;
        logic [23:0] addr;
        logic [7:0]  dout;
    } host_dl_t;

    // CPU external memory request
    typedef struct packed {
        logic        sel;
        logic        r_wn;
        logic [15:0] addr;
        logic [7:0]  data;
    } cpu_req_t;

    // External memory port
    typedef struct packed {
        logic [22:0] addr;
        logic [7:0]  din;
        logic        we;
        logic        oe;
    } mem_req_t;

    // Write beat from the loader or the pointer injector
    typedef struct packed {
        logic [15:0] addr;
        logic [7:0]  data;
        logic        wr;
    } load_wr_t;

endpackage

// ==== design/vic_loader_top.sv ====
/*
  Media loader and memory port of the VIC-20 core.
  The host holds addr, dout and download for at least one cycle after wr.
  CPU read data is the raw memory output.
*/
module vic_loader_top (
    input  logic                     clk_sys,
    input  logic                     reset,
    input  vic_loader_pkg::host_dl_t host_i,
    input  logic                     no_load_addr_i,
    input  vic_loader_pkg::cpu_req_t cpu_i,
    input  logic                     p2_h_i,
    input  logic [7:0]               mem_dout_i,
    input  logic                     tap_full_i,
    output vic_loader_pkg::mem_req_t mem_o,
    output vic_loader_pkg::load_wr_t conf_o,
    output logic [7:0]               cpu_dout_o,
    output logic                     force_reset_o,
    output logic [7:0]               tap_data_o,
    output logic                     tap_wrreq_o,
    output logic                     tap_version_o
);
    vic_loader_pkg::dl_kind_t kind;
    vic_loader_pkg::load_wr_t inject;
    vic_loader_pkg::load_wr_t load_beat;
    logic [15:0]              prg_addr;
    logic [22:0]              tap_addr;
    logic [22:0]              target;
    logic [22:0]              play_addr;
    logic                     internal;
    logic                     ram_wr;
    logic                     cart_hit;
    logic                     tap_oe;

    // Injector and loader beats never overlap
    assign load_beat  = inject.wr ? inject : '{addr: prg_addr, data: host_i.dout, wr: ram_wr};
    assign cpu_dout_o = mem_dout_i;

    load_addr_map u_load_addr_map (
        .host_i     (host_i),
        .prg_addr_i (prg_addr),
        .tap_addr_i (tap_addr),
        .inject_i   (inject),
        .kind_o     (kind),
        .target_o   (target),
        .internal_o (internal)
    );

    prg_loader u_prg_loader (
        .clk_sys        (clk_sys),
        .reset          (reset),
        .host_i         (host_i),
        .kind_i         (kind),
        .no_load_addr_i (no_load_addr_i),
        .prg_addr_o     (prg_addr),
        .tap_addr_o     (tap_addr),
        .ram_wr_o       (ram_wr),
        .cart_hit_o     (cart_hit)
    );

    basic_ptr_inject u_basic_ptr_inject (
        .clk_sys       (clk_sys),
        .reset         (reset),
        .kind_i        (kind),
        .prg_addr_i    (prg_addr),
        .cart_hit_i    (cart_hit),
        .inject_o      (inject),
        .force_reset_o (force_reset_o)
    );

    tape_fetch u_tape_fetch (
        .clk_sys       (clk_sys),
        .reset         (reset),
        .host_i        (host_i),
        .kind_i        (kind),
        .tap_addr_i    (tap_addr),
        .p2_h_i        (p2_h_i),
        .mem_dout_i    (mem_dout_i),
        .tap_full_i    (tap_full_i),
        .play_addr_o   (play_addr),
        .oe_o          (tap_oe),
        .tap_data_o    (tap_data_o),
        .tap_wrreq_o   (tap_wrreq_o),
        .tap_version_o (tap_version_o)
    );

    mem_port_mux u_mem_port_mux (
        .kind_i     (kind),
        .p2_h_i     (p2_h_i),
        .cpu_i      (cpu_i),
        .load_i     (load_beat),
        .target_i   (target),
        .internal_i (internal),
        .host_i     (host_i),
        .tap_addr_i (play_addr),
        .tap_oe_i   (tap_oe),
        .mem_o      (mem_o),
        .conf_o     (conf_o)
    );

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the loader testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_vic_loader -f build.f

./obj_dir/Vtb_vic_loader > sim.log 2>&1 || true
cat sim.log

if grep -q "=== PASS ===" sim.log; then
    exit 0
fi
exit 1

// ==== test/tb_vic_loader.sv ====
/*
  Testbench for the media loader: ROM, PRG, TAP images and CPU traffic.
  Each host byte takes two cycles, wr high then low with addr and data held.
  TAP byte 0 is neither stored nor played back.
*/
`include "vic_loader_config.svh"

module tb_vic_loader;
    import vic_loader_pkg::*;

    // Longest test is the TAP playback, well under 2000 cycles
    localparam int MAX_CYCLES = 40000;
    localparam logic [15:0] PTRS [8] = '{
        `VL_PTR_ADDR_0, `VL_PTR_ADDR_1, `VL_PTR_ADDR_2, `VL_PTR_ADDR_3,
        `VL_PTR_ADDR_4, `VL_PTR_ADDR_5, `VL_PTR_ADDR_6, `VL_PTR_ADDR_7
    };

    logic        clk_sys = 1'b0;
    logic        reset;
    host_dl_t    host;
    logic        no_load_addr;
    cpu_req_t    cpu;
    logic        p2_h;
    logic [7:0]  mem_dout;
    logic        tap_full;
    mem_req_t    mem_o;
    load_wr_t    conf_o;
    logic [7:0]  cpu_dout;
    logic        force_reset;
    logic [7:0]  tap_data;
    logic        tap_wrreq;
    logic        tap_version;

    logic [7:0]  mem [int];
    logic [7:0]  conf_mem [int];
    logic [7:0]  exp_mem [int];
    logic [7:0]  exp_conf [int];
    logic [7:0]  tap_got [$];
    logic [7:0]  img [$];
    int          errors = 0;
    int          cycles = 0;
    int          reset_pulses = 0;
    int          exp_pulses = 0;
    int          inject_beats = 0;

    vic_loader_top u_vic_loader_top (
        .clk_sys        (clk_sys),
        .reset          (reset),
        .host_i         (host),
        .no_load_addr_i (no_load_addr),
        .cpu_i          (cpu),
        .p2_h_i         (p2_h),
        .mem_dout_i     (mem_dout),
        .tap_full_i     (tap_full),
        .mem_o          (mem_o),
        .conf_o         (conf_o),
        .cpu_dout_o     (cpu_dout),
        .force_reset_o  (force_reset),
        .tap_data_o     (tap_data),
        .tap_wrreq_o    (tap_wrreq),
        .tap_version_o  (tap_version)
    );

    always #5 clk_sys = ~clk_sys;

    // Unwritten memory returns a pattern of the whole address
    function automatic logic [7:0] mem_read(input logic [22:0] a);
        if (mem.exists(int'(a))) begin
            return mem[int'(a)];
        end
        return a[7:0] ^ a[15:8] ^ {1'b0, a[22:16]} ^ 8'h5A;
    endfunction

    function automatic logic [22:0] rom_target(input logic [15:0] a);
        case (a[15:13])
            3'd0, 3'd1: return {7'h0, a};
            3'd2, 3'd3: return {7'h0, 16'hE000 + {3'b000, a[12:0]}};
            3'd4:       return {7'h0, 16'hC000 + {3'b000, a[12:0]}};
            default:    return {7'h0, 16'h8000 + {4'b0000, a[11:0]}};
        endcase
    endfunction

    function automatic logic prg_is_internal(input logic [15:0] a);
        return a < 16'h0400 || (a >= 16'h1000 && a < 16'h2000) ||
               (a >= 16'h9400 && a < 16'h9800);
    endfunction

    // ============================================================
    // Memory model and monitors
    // ============================================================
    always @(posedge clk_sys) begin
        mem_dout <= mem_read(mem_o.addr);
        if (mem_o.we) begin
            mem[int'(mem_o.addr)] = mem_o.din;
        end
        if (conf_o.wr) begin
            conf_mem[int'(conf_o.addr)] = conf_o.data;
            if (!host.download) begin
                inject_beats++;
            end
        end
        if (tap_wrreq) begin
            tap_got.push_back(tap_data);
        end
        if (force_reset) begin
            reset_pulses++;
        end
    end

    always @(posedge clk_sys) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("Errors: %0d  Assertion failures: %0d", errors,
                     u_vic_loader_top.u_vic_loader_chk.fail_count);
            $display("=== FAIL ===");
            $finish;
        end
    end

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("Mismatch at time %0t: %s got %0h expected %0h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic send_byte(input logic [7:0] idx, input int a, input logic [7:0] d);
        @(posedge clk_sys);
        host <= '{download: 1'b1, index: idx, wr: 1'b1, addr: 24'(a), dout: d};
        @(posedge clk_sys);
        host.wr <= 1'b0;
    endtask

    task automatic end_download();
        @(posedge clk_sys);
        host <= '0;
        @(posedge clk_sys);
    endtask

    task automatic start_image();
        mem.delete();
        conf_mem.delete();
        exp_mem.delete();
        exp_conf.delete();
    endtask

    task automatic verify_image(input string what);
        foreach (exp_mem[k]) begin
            check_value({what, " memory byte"}, 32'(mem_read(23'(k))), 32'(exp_mem[k]));
        end
        foreach (exp_conf[k]) begin
            if (conf_mem.exists(k)) begin
                check_value({what, " conf byte"}, 32'(conf_mem[k]), 32'(exp_conf[k]));
            end else begin
                $display("Missing configuration write at %0h in %s", k, what);
                errors++;
            end
        end
        // Each byte goes to one side only
        foreach (mem[k]) begin
            if (!exp_mem.exists(k)) begin
                $display("Unexpected memory write at %0h in %s", k, what);
                errors++;
            end
        end
        foreach (conf_mem[k]) begin
            if (!exp_conf.exists(k)) begin
                $display("Unexpected configuration write at %0h in %s", k, what);
                errors++;
            end
        end
    endtask

    // Waits for the eight pointer beats and the end of the sequence
    task automatic finish_prg(input logic [15:0] last_addr);
        int start;
        start = inject_beats;
        end_download();
        while (inject_beats < start + 8) begin
            @(posedge clk_sys);
        end
        repeat (24) @(posedge clk_sys);
        for (int i = 0; i < 8; i++) begin
            exp_conf[int'(PTRS[i])] = (i % 2 == 0) ? last_addr[7:0] : last_addr[15:8];
        end
        verify_image("PRG");
        check_value("reset pulses", 32'(reset_pulses), 32'(exp_pulses));
    endtask

    task automatic load_prg(input logic no_load, input int n);
        logic [15:0] a;
        logic [7:0]  d;
        logic        hit;
        hit = 1'b0;
        a = 16'h0380 + 16'($urandom % 64);
        start_image();
        no_load_addr <= no_load;
        if (!no_load) begin
            send_byte(8'h01, 0, a[7:0]);
            send_byte(8'h01, 1, a[15:8]);
        end else begin
            a = `VL_PRG_CART_ADDR;
        end
        for (int k = 0; k < n; k++) begin
            d = 8'($urandom);
            send_byte(8'h01, no_load ? k : k + 2, d);
            if (prg_is_internal(a)) begin
                exp_conf[int'(a)] = d;
            end else begin
                exp_mem[int'(a)] = d;
            end
            hit = hit | (a == 16'hA000);
            a = a + 16'd1;
        end
        if (hit) begin
            exp_pulses++;
        end
        finish_prg(a - 16'd1);
        no_load_addr <= 1'b0;
    endtask

    task automatic cpu_op();
        logic [15:0] a;
        logic        rd;
        logic [7:0]  d;
        logic [7:0]  exp;
        a = 16'h1000 + 16'($urandom % 32);
        rd = 1'($urandom);
        d = 8'($urandom);
        @(posedge clk_sys);
        cpu <= '{sel: 1'b1, r_wn: rd, addr: a, data: d};
        @(negedge clk_sys);
        check_value("CPU address", 32'(mem_o.addr), 32'({7'h0, a}));
        check_value("CPU din", 32'(mem_o.din), 32'(d));
        check_value("CPU we", 32'(mem_o.we), 32'(!rd));
        check_value("CPU oe", 32'(mem_o.oe), 32'(rd));
        exp = mem_read({7'h0, a});
        @(posedge clk_sys);
        cpu.sel <= 1'b0;
        @(negedge clk_sys);
        if (rd) begin
            check_value("CPU read data", 32'(cpu_dout), 32'(exp));
        end
    endtask

    // ============================================================
    // Test sequence
    // ============================================================
    initial begin
        logic [15:0] a;
        logic [7:0]  d;
        logic [22:0] t;
        int          assert_fails;
        void'($urandom(32'h7550));
        reset = 1'b1;
        host = '0;
        no_load_addr = 1'b0;
        cpu = '0;
        p2_h = 1'b0;
        mem_dout = 8'h00;
        tap_full = 1'b0;
        repeat (2) @(posedge clk_sys);
        reset <= 1'b0;

        // ROM with addresses spread over the six windows
        start_image();
        for (int k = 0; k < 64; k++) begin
            a = {3'(k % 6), 13'($urandom)};
            d = 8'($urandom);
            t = rom_target(a);
            send_byte(8'h00, int'(a), d);
            if (t[15:14] != 2'b00) begin
                exp_conf[int'(t)] = d;
            end else begin
                exp_mem[int'(t)] = d;
            end
        end
        end_download();
        verify_image("ROM");

        load_prg(1'b0, 40 + int'($urandom % 40));
        load_prg(1'b1, 48);

        // TAP image, then playback paced by p2_h
        start_image();
        img.delete();
        tap_got.delete();
        for (int k = 0; k < 40; k++) begin
            img.push_back(8'($urandom));
            send_byte(8'h81, k, img[k]);
            if (k > 0) begin
                exp_mem[int'(`VL_TAP_BASE) + k] = img[k];
            end
        end
        end_download();
        verify_image("TAP");
        check_value("TAP version", 32'(tap_version), 32'(img[12][0]));
        while (tap_got.size() < img.size() - 1) begin
            @(posedge clk_sys);
            p2_h <= 1'b1;
            tap_full <= ($urandom % 4 == 0);
            @(posedge clk_sys);
            @(posedge clk_sys);
            p2_h <= 1'b0;
            repeat (4) @(posedge clk_sys);
        end
        repeat (20) @(posedge clk_sys);
        check_value("TAP byte count", 32'(tap_got.size()), 32'(img.size() - 1));
        for (int i = 0; i < tap_got.size() && i + 1 < img.size(); i++) begin
            check_value("TAP playback byte", 32'(tap_got[i]), 32'(img[i + 1]));
        end

        // CPU traffic while p2_h is high
        tap_full <= 1'b0;
        p2_h <= 1'b1;
        for (int k = 0; k < 40; k++) begin
            cpu_op();
        end

        assert_fails = u_vic_loader_top.u_vic_loader_chk.fail_count;
        $display("Errors: %0d  Assertion failures: %0d", errors, assert_fails);
        if (errors == 0 && assert_fails == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// ==== test/vic_loader_chk.sv ====
/*
  Concurrent checks on the loader top level, attached with bind.
  A PRG download counts as seen once download is high with a PRG index.
*/
module vic_loader_chk (
    input  logic                     clk_sys,
    input  logic                     reset,
    input  vic_loader_pkg::host_dl_t host_i,
    input  vic_loader_pkg::mem_req_t mem_o,
    input  logic                     force_reset_o,
    input  logic                     tap_wrreq_o
);
    logic prg_seen;

    // Failed assertions so far
    int   fail_count = 0;

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            prg_seen <= 1'b0;
        end else if (host_i.download && (host_i.index == 8'h01 || host_i.index == 8'h41)) begin
            prg_seen <= 1'b1;
        end
    end

    // FIFO write request is a single-cycle pulse
    a_wrreq_pulse: assert property (@(posedge clk_sys) disable iff (reset)
        tap_wrreq_o |=> !tap_wrreq_o)
        else begin
            $error("tap_wrreq_o held high for more than one cycle");
            fail_count++;
        end

    a_we_oe: assert property (@(posedge clk_sys) disable iff (reset)
        !(mem_o.we && mem_o.oe))
        else begin
            $error("memory write and read enable both high");
            fail_count++;
        end

    a_reset_after_prg: assert property (@(posedge clk_sys) disable iff (reset)
        force_reset_o |-> prg_seen)
        else begin
            $error("force_reset_o pulsed without a PRG download");
            fail_count++;
        end

endmodule

bind vic_loader_top vic_loader_chk u_vic_loader_chk (
    .clk_sys       (clk_sys),
    .reset         (reset),
    .host_i        (host_i),
    .mem_o         (mem_o),
    .force_reset_o (force_reset_o),
    .tap_wrreq_o   (tap_wrreq_o)
);
